// File: rv_pipe.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/pipe_ctrl_pkg.sv
hdl/ex_mem_if.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/stall.sv
hdl/rv_pipe.sv
bench/rv_pipe_sva.sv
bench/rv_pipe_tb.sv

// File: bench/rv_pipe_tb.sv
// RV32I pipeline testbench
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_pipe_tb import rv_isa_pkg::*; ();

    localparam int N_RAND  = 40;
    localparam int N_PROG  = N_RAND + `REG_COUNT + 1;   // random part, register dump, ecall
    localparam int TIMEOUT = 4000;
    localparam int T_RESET = 0;
    localparam int T_STREAM = 1;
    localparam int T_ARITH = 2;
    localparam int T_LOAD  = 3;
    localparam int T_STALL = 4;
    localparam int T_HALT  = 5;

    logic              clk;
    logic              rst = 1'b1;
    logic              imem_req;
    logic [`XLEN-1:0]  imem_addr;
    logic              imem_resp = 1'b0;
    logic [`XLEN-1:0]  imem_rdata = '0;
    logic              dmem_req;
    logic              dmem_we;
    logic [`XLEN-1:0]  dmem_addr;
    logic [`XLEN-1:0]  dmem_wdata;
    logic              dmem_resp = 1'b0;
    logic [`XLEN-1:0]  dmem_rdata = '0;
    logic              halted;

    integer            seed = 32'h3c19_da36;
    rv_opcode_e        p_op [N_PROG];
    logic [4:0]        p_rd [N_PROG];
    logic [4:0]        p_rs1 [N_PROG];
    logic [4:0]        p_rs2 [N_PROG];
    logic [11:0]       p_imm [N_PROG];
    logic [`XLEN-1:0]  prog [N_PROG];
    logic [`XLEN-1:0]  data_mem [logic [`XLEN-1:0]];
    logic [`XLEN-1:0]  model_mem [logic [`XLEN-1:0]];
    logic [`XLEN-1:0]  exp_addr [$];
    logic [`XLEN-1:0]  exp_data [$];
    logic [`XLEN-1:0]  imem_pend, dmem_pend;
    int                imem_left = 0;
    int                dmem_left = 0;
    int                imem_lat = 1;
    int                dmem_lat = 1;
    int                n_arith_stores, n_mem_ops;
    int                imem_count, dmem_count, store_count, late_reqs;
    int                both_now, imem_first, dmem_first;
    bit                imem_out, dmem_out;
    int                checks [6];
    int                errors [6];
    string             test_name [6] = '{"reset", "instruction stream", "arithmetic stores",
                                         "load and register dump", "stalls", "halt"};

    rv_pipe rv_pipe_inst (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    bind rv_pipe rv_pipe_sva rv_pipe_sva_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_req  (imem_req),
        .imem_resp (imem_resp),
        .dmem_req  (dmem_req),
        .dmem_resp (dmem_resp),
        .move      (move),
        .halted    (halted),
        .state     (stall_inst.state_q)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // untouched data memory returns a pattern built from the address
    function automatic logic [`XLEN-1:0] fill_word(input logic [`XLEN-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6d2b_79f5;
    endfunction

    function automatic logic [`XLEN-1:0] read_data(input logic [`XLEN-1:0] addr);
        if (data_mem.exists(addr)) return data_mem[addr];
        return fill_word(addr);
    endfunction

    function automatic logic [`XLEN-1:0] model_load(input logic [`XLEN-1:0] addr);
        if (model_mem.exists(addr)) return model_mem[addr];
        return fill_word(addr);
    endfunction

    function automatic logic [`XLEN-1:0] instr_at(input logic [`XLEN-1:0] addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < N_PROG) return prog[addr >> 2];
        return '0;
    endfunction

    function automatic logic [`XLEN-1:0] encode(
        input rv_opcode_e  op,
        input logic [4:0]  rd,
        input logic [4:0]  rs1,
        input logic [4:0]  rs2,
        input logic [11:0] imm
    );
        case (op)
            op_addi: return {imm, rs1, 3'b000, rd, 7'b0010011};
            op_add:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            op_sub:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            op_xor:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            op_or:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            op_and:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            op_lw:   return {imm, rs1, 3'b010, rd, 7'b0000011};
            op_sw:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            default: return 32'h0000_0073;
        endcase
    endfunction

    task automatic build_program();
        integer     r;
        logic [4:0] prev_rd;
        rv_opcode_e kinds [8] = '{op_addi, op_add, op_sub, op_and, op_or, op_xor, op_lw, op_sw};
        prev_rd = 5'd1;
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            p_op[i]  = (i < 6) ? op_addi : kinds[r[2:0]];  // seed some registers first
            p_rd[i]  = r[7:3];
            p_rs1[i] = r[8] ? prev_rd : r[13:9];           // often depends on the previous result
            p_rs2[i] = r[14] ? prev_rd : r[19:15];
            p_imm[i] = r[31:20];
            if (p_op[i] == op_lw || p_op[i] == op_sw) begin
                p_rs1[i] = 5'd0;
                p_imm[i] = 12'h400 + {6'd0, r[23:20], 2'b00};
            end
            if (p_op[i] != op_sw) prev_rd = p_rd[i];
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            p_op[N_RAND+i]  = op_sw;
            p_rd[N_RAND+i]  = 5'd0;
            p_rs1[N_RAND+i] = 5'd0;
            p_rs2[N_RAND+i] = i[4:0];
            p_imm[N_RAND+i] = 12'h600 + 12'(4 * i);
        end
        p_op[N_PROG-1] = op_ecall;
        for (int i = 0; i < N_PROG; i++) begin
            prog[i] = encode(p_op[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
        end
    endtask

    // in-order instruction set model, records every store it makes
    task automatic run_model();
        logic [`XLEN-1:0] x [`REG_COUNT];
        logic [`XLEN-1:0] a, b, imm, res;
        for (int i = 0; i < `REG_COUNT; i++) x[i] = '0;
        for (int i = 0; i < N_PROG; i++) begin
            a   = x[p_rs1[i]];
            b   = x[p_rs2[i]];
            imm = {{20{p_imm[i][11]}}, p_imm[i]};
            res = '0;
            case (p_op[i])
                op_addi: res = a + imm;
                op_add:  res = a + b;
                op_sub:  res = a - b;
                op_and:  res = a & b;
                op_or:   res = a | b;
                op_xor:  res = a ^ b;
                op_lw:   res = model_load(a + imm);
                op_sw: begin
                    model_mem[a + imm] = b;
                    exp_addr.push_back(a + imm);
                    exp_data.push_back(b);
                    if (i < N_RAND) n_arith_stores++;
                end
                default: ;
            endcase
            if (p_op[i] == op_lw || p_op[i] == op_sw) n_mem_ops++;
            if (p_op[i] != op_sw && p_op[i] != op_ecall && p_rd[i] != 5'd0) x[p_rd[i]] = res;
        end
    endtask

    task automatic report_mismatch(input int t, input string sig, input logic [`XLEN-1:0] got,
                                   input logic [`XLEN-1:0] exp);
        $display("Mismatch at %0t: %s is %h, expected %h", $time, sig, got, exp);
        errors[t]++;
    endtask

    task automatic flag_error(input int t, input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors[t]++;
    endtask

    task automatic finish_test(input int t, input string note);
        $display("test %0d %s: %0d checks, %0d errors, %s%s", t + 1, test_name[t], checks[t],
                 errors[t], (errors[t] == 0) ? "passed" : "failed", note);
    endtask

    // both latencies come from one place so the random sequence is the same on every run
    always @(posedge clk) begin
        imem_lat <= 1 + ($random(seed) & 3);
        dmem_lat <= 1 + ($random(seed) & 3);
    end

    always @(posedge clk) begin : instr_memory
        imem_resp <= 1'b0;
        if (rst) begin
            imem_left <= 0;
        end else if (imem_req) begin
            imem_pend <= imem_addr;
            imem_left <= imem_lat - 1;
            if (imem_lat == 1) begin
                imem_resp  <= 1'b1;
                imem_rdata <= instr_at(imem_addr);
            end
        end else if (imem_left > 0) begin
            imem_left <= imem_left - 1;
            if (imem_left == 1) begin
                imem_resp  <= 1'b1;
                imem_rdata <= instr_at(imem_pend);
            end
        end
    end

    always @(posedge clk) begin : data_memory
        dmem_resp <= 1'b0;
        if (rst) begin
            dmem_left <= 0;
        end else if (dmem_req) begin
            if (dmem_we) data_mem[dmem_addr] = dmem_wdata;
            dmem_pend <= read_data(dmem_addr);
            dmem_left <= dmem_lat - 1;
            if (dmem_lat == 1) begin
                dmem_resp  <= 1'b1;
                dmem_rdata <= read_data(dmem_addr);
            end
        end else if (dmem_left > 0) begin
            dmem_left <= dmem_left - 1;
            if (dmem_left == 1) begin
                dmem_resp  <= 1'b1;
                dmem_rdata <= dmem_pend;
            end
        end
    end

    always @(posedge clk) begin : bus_monitor
        logic [`XLEN-1:0] exp_pc;
        int               t;
        if (!rst) begin
            if (imem_req) begin
                exp_pc = `RESET_PC + 4 * imem_count;
                checks[T_STREAM]++;
                assert (imem_addr == exp_pc)
                    else report_mismatch(T_STREAM, "imem_addr", imem_addr, exp_pc);
                imem_count++;
            end
            if (dmem_req) dmem_count++;
            if (dmem_req && dmem_we) begin
                t = (store_count < n_arith_stores) ? T_ARITH : T_LOAD;
                checks[t]++;
                assert (exp_addr.size() > 0) else flag_error(t, "store beyond the expected ones");
                if (exp_addr.size() > 0) begin
                    assert (dmem_addr == exp_addr[0])
                        else report_mismatch(t, "dmem_addr", dmem_addr, exp_addr[0]);
                    assert (dmem_wdata == exp_data[0])
                        else report_mismatch(t, "dmem_wdata", dmem_wdata, exp_data[0]);
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                end
                store_count++;
            end
            if (halted && (imem_req || dmem_req)) late_reqs++;
            if (imem_out && dmem_out) begin    // both memories busy, note who answers first
                if (imem_resp && dmem_resp) both_now++;
                else if (imem_resp) imem_first++;
                else if (dmem_resp) dmem_first++;
            end
            if (imem_req) imem_out = 1'b1;
            else if (imem_resp) imem_out = 1'b0;
            if (dmem_req) dmem_out = 1'b1;
            else if (dmem_resp) dmem_out = 1'b0;
        end
    end

    task automatic check_reset();
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 10) begin
            @(posedge clk);
            cycles++;
            checks[T_RESET]++;
            assert (!halted && !dmem_req && !dmem_we)
                else flag_error(T_RESET, "halted or a data request is high after reset");
            if (imem_req) begin
                seen = 1'b1;
                assert (imem_addr == `RESET_PC)
                    else report_mismatch(T_RESET, "imem_addr", imem_addr, `RESET_PC);
            end
        end
        assert (seen) else flag_error(T_RESET, "no instruction request came after reset");
        finish_test(T_RESET, "");
    endtask

    initial begin : main
        int cycles;
        int total_checks;
        int total_errors;
        int passed;
        build_program();
        run_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        check_reset();

        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        checks[T_HALT]++;
        assert (halted) else flag_error(T_HALT, "halted did not rise before the timeout");
        cycles = 0;
        while (cycles < 20) begin   // quiet window, longer than any memory latency
            @(posedge clk);
            cycles++;
        end

        finish_test(T_STREAM, "");
        finish_test(T_ARITH, "");
        checks[T_LOAD]++;
        assert (exp_addr.size() == 0)
            else flag_error(T_LOAD, $sformatf("%0d expected stores never came", exp_addr.size()));
        finish_test(T_LOAD, "");
        checks[T_STALL] += 4;
        assert (imem_first > 0)
            else flag_error(T_STALL, "instruction memory never answered first");
        assert (dmem_first > 0)
            else flag_error(T_STALL, "data memory never answered first");
        assert (both_now > 0)
            else flag_error(T_STALL, "the two memories never answered in the same cycle");
        assert (rv_pipe_inst.rv_pipe_sva_inst.fail_count == 0)
            else flag_error(T_STALL, "the bound handshake assertions failed");
        finish_test(T_STALL, $sformatf(" (imem first %0d, dmem first %0d, together %0d)",
                                       imem_first, dmem_first, both_now));
        checks[T_HALT] += 3;
        assert (imem_count == N_PROG)
            else report_mismatch(T_HALT, "imem request count", imem_count, N_PROG);
        assert (dmem_count == n_mem_ops)
            else report_mismatch(T_HALT, "dmem request count", dmem_count, n_mem_ops);
        assert (late_reqs == 0) else flag_error(T_HALT, "a request was issued after halted");
        finish_test(T_HALT, "");

        total_checks = 0;
        total_errors = 0;
        passed = 0;
        for (int t = 0; t < 6; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
            if (errors[t] == 0) passed++;
        end
        $display("%0d of 6 tests passed, %0d checks, %0d errors", passed, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: bench/rv_pipe_sva.sv
// Handshake and stall protocol checks
`timescale 1ns/1ps

module rv_pipe_sva import pipe_ctrl_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         imem_req,
    input logic         imem_resp,
    input logic         dmem_req,
    input logic         dmem_resp,
    input logic         move,
    input logic         halted,
    input stall_state_e state
);

    logic imem_busy;   // a request is waiting for its response
    logic dmem_busy;
    int   fail_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            imem_busy <= 1'b0;
            dmem_busy <= 1'b0;
        end else begin
            if (imem_req) imem_busy <= 1'b1;
            else if (imem_resp) imem_busy <= 1'b0;
            if (dmem_req) dmem_busy <= 1'b1;
            else if (dmem_resp) dmem_busy <= 1'b0;
        end
    end

    // a new request may share the cycle with the response that frees the port
    single_imem: assert property (@(posedge clk) disable iff (rst)
        imem_req |-> (!imem_busy || imem_resp))
        else begin
            $error("instruction request while one is outstanding");
            fail_count++;
        end

    single_dmem: assert property (@(posedge clk) disable iff (rst)
        dmem_req |-> (!dmem_busy || dmem_resp))
        else begin
            $error("data request while one is outstanding");
            fail_count++;
        end

    move_complete: assert property (@(posedge clk) disable iff (rst)
        move |-> ((!imem_busy || imem_resp) && (!dmem_busy || dmem_resp)))
        else begin
            $error("pipeline advanced with a response still outstanding");
            fail_count++;
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
        halted |-> (!imem_req && !dmem_req))
        else begin
            $error("request issued after halt");
            fail_count++;
        end

    moving_idle: assert property (@(posedge clk) disable iff (rst)
        (state == moving) |-> (!imem_busy && !dmem_busy))
        else begin
            $error("stall controller in moving state with memory busy");
            fail_count++;
        end

endmodule

// File: hdl/rv_pipe.sv
// Three-stage RV32I pipeline
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_pipe (
    input  logic              clk,
    input  logic              rst,

    output logic              imem_req,
    output logic [`XLEN-1:0]  imem_addr,
    input  logic              imem_resp,
    input  logic [`XLEN-1:0]  imem_rdata,

    output logic              dmem_req,
    output logic              dmem_we,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata,
    input  logic              dmem_resp,
    input  logic [`XLEN-1:0]  dmem_rdata,

    output logic              halted
);

    logic                          move;
    logic                          halt;
    logic                          if_valid;
    logic [`XLEN-1:0]              if_pc;
    logic [`XLEN-1:0]              if_instr;
    logic                          wb_we;
    logic [$clog2(`REG_COUNT)-1:0] wb_rd;
    logic [`XLEN-1:0]              wb_data;

    ex_mem_if ex_mem ();

    stall stall_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_req  (imem_req),
        .dmem_req  (dmem_req),
        .imem_resp (imem_resp),
        .dmem_resp (dmem_resp),
        .move      (move)
    );

    fetch_stage fetch_inst (
        .clk        (clk),
        .rst        (rst),
        .move       (move),
        .halt       (halt),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_instr   (if_instr),
        .halted     (halted)
    );

    execute_stage execute_inst (
        .clk      (clk),
        .rst      (rst),
        .move     (move),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .halt     (halt),
        .ex_out   (ex_mem)
    );

    mem_stage mem_inst (
        .clk        (clk),
        .rst        (rst),
        .move       (move),
        .ex_in      (ex_mem),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

// File: hdl/stall.sv
// Pipeline advance controller
`timescale 1ns/1ps

module stall import pipe_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic imem_req,
    input  logic dmem_req,
    input  logic imem_resp,
    input  logic dmem_resp,
    output logic move
);

    stall_state_e state_q, state_d;
    stall_state_e next_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    // what the beat that starts now has to wait for
    always_comb begin
        case ({imem_req, dmem_req})
            2'b10:   next_beat = wait_imem;
            2'b01:   next_beat = wait_dmem;
            2'b11:   next_beat = imem_dmem;
            default: next_beat = moving;
        endcase
    end

    always_comb begin
        case (state_q)
            idle:      move = imem_resp;
            wait_imem: move = imem_resp;
            wait_dmem: move = dmem_resp;
            imem_dmem: move = imem_resp && dmem_resp;
            moving:    move = 1'b1;
            default:   move = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        if (move) begin
            state_d = next_beat;
        end else if (state_q == imem_dmem) begin
            // one of the two arrived, keep waiting for the other
            if (imem_resp) state_d = wait_dmem;
            else if (dmem_resp) state_d = wait_imem;
        end
    end

endmodule

// File: hdl/mem_stage.sv
// Data memory access and writeback
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module mem_stage import rv_isa_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          move,
    ex_mem_if.memory                      ex_in,
    output logic                          dmem_req,
    output logic                          dmem_we,
    output logic [`XLEN-1:0]              dmem_addr,
    output logic [`XLEN-1:0]              dmem_wdata,
    input  logic                          dmem_resp,
    input  logic [`XLEN-1:0]              dmem_rdata,
    output logic                          wb_we,
    output logic [$clog2(`REG_COUNT)-1:0] wb_rd,
    output logic [`XLEN-1:0]              wb_data
);

    logic                          m_valid;
    rv_opcode_e                    m_op;
    logic [$clog2(`REG_COUNT)-1:0] m_rd;
    logic [`XLEN-1:0]              m_result;
    logic [`XLEN-1:0]              load_q;
    logic                          is_mem;
    logic                          m_writes;

    // request goes out for the instruction that is entering this stage
    assign is_mem     = ex_in.valid && (ex_in.op == op_lw || ex_in.op == op_sw);
    assign dmem_req   = move && is_mem;
    assign dmem_we    = move && ex_in.valid && ex_in.op == op_sw;
    assign dmem_addr  = ex_in.result;
    assign dmem_wdata = ex_in.store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (move) begin
            m_valid <= ex_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            m_op     <= ex_in.op;
            m_rd     <= ex_in.rd;
            m_result <= ex_in.result;
        end
        if (dmem_resp) load_q <= dmem_rdata;
    end

    assign m_writes = m_op inside {op_addi, op_add, op_sub, op_and, op_or, op_xor, op_lw};

    // write only on the move edge so execute sees the value through its bypass
    assign wb_we   = move && m_valid && m_writes;
    assign wb_rd   = m_rd;
    assign wb_data = (m_op != op_lw) ? m_result : (dmem_resp ? dmem_rdata : load_q);

endmodule

// File: hdl/execute_stage.sv
// Decode, register file and ALU
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module execute_stage import rv_isa_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          move,
    input  logic                          if_valid,
    input  logic [`XLEN-1:0]              if_pc,
    input  logic [`XLEN-1:0]              if_instr,
    input  logic                          wb_we,
    input  logic [$clog2(`REG_COUNT)-1:0] wb_rd,
    input  logic [`XLEN-1:0]              wb_data,
    output logic                          halt,
    ex_mem_if.execute                     ex_out
);

    localparam int RW = $clog2(`REG_COUNT);

    logic              e_valid;
    logic [`XLEN-1:0]  e_instr;
    logic [`XLEN-1:0]  e_pc;
    logic [`XLEN-1:0]  regs [`REG_COUNT];
    rv_opcode_e        op;
    alu_op_e           alu_op;
    logic [`XLEN-1:0]  rs1_val, rs2_val;
    logic [`XLEN-1:0]  imm_i, imm_s, opnd_b;
    logic [`XLEN-1:0]  alu_out;

    function automatic rv_opcode_e decode(input logic [`XLEN-1:0] w);
        rv_opcode_e k;
        k = op_illegal;
        case (w[6:0])
            7'b0010011: if (w[14:12] == 3'b000) k = op_addi;
            7'b0110011: begin
                if (w[31:25] == 7'b0100000 && w[14:12] == 3'b000) begin
                    k = op_sub;
                end else if (w[31:25] == 7'b0000000) begin
                    case (w[14:12])
                        3'b000:  k = op_add;
                        3'b100:  k = op_xor;
                        3'b110:  k = op_or;
                        3'b111:  k = op_and;
                        default: k = op_illegal;
                    endcase
                end
            end
            7'b0000011: if (w[14:12] == 3'b010) k = op_lw;
            7'b0100011: if (w[14:12] == 3'b010) k = op_sw;
            7'b1110011: if (w == `XLEN'h0000_0073) k = op_ecall;
            default:    k = op_illegal;
        endcase
        return k;
    endfunction

    // the writeback of the previous instruction lands on this same edge, so bypass it
    function automatic logic [`XLEN-1:0] read_reg(input logic [RW-1:0] idx);
        if (idx == '0) return '0;
        if (wb_we && wb_rd == idx) return wb_data;
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid <= 1'b0;
        end else if (move) begin
            e_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            e_instr <= if_instr;
            e_pc    <= if_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // stop fetch as soon as ecall is handed over
    assign halt = if_valid && decode(if_instr) == op_ecall;

    assign op      = decode(e_instr);
    assign rs1_val = read_reg(e_instr[19:15]);
    assign rs2_val = read_reg(e_instr[24:20]);
    assign imm_i   = {{20{e_instr[31]}}, e_instr[31:20]};
    assign imm_s   = {{20{e_instr[31]}}, e_instr[31:25], e_instr[11:7]};

    always_comb begin
        alu_op = alu_add;       // addi, add, lw and sw all add
        opnd_b = rs2_val;
        case (op)
            op_sub: alu_op = alu_sub;
            op_and: alu_op = alu_and;
            op_or:  alu_op = alu_or;
            op_xor: alu_op = alu_xor;
            default: alu_op = alu_add;
        endcase
        if (op == op_addi || op == op_lw) opnd_b = imm_i;
        else if (op == op_sw) opnd_b = imm_s;
    end

    always_comb begin
        case (alu_op)
            alu_sub: alu_out = rs1_val - opnd_b;
            alu_and: alu_out = rs1_val & opnd_b;
            alu_or:  alu_out = rs1_val | opnd_b;
            alu_xor: alu_out = rs1_val ^ opnd_b;
            default: alu_out = rs1_val + opnd_b;
        endcase
    end

    assign ex_out.valid      = e_valid;
    assign ex_out.op         = op;
    assign ex_out.rd         = e_instr[11:7];
    assign ex_out.result     = (op == op_ecall) ? e_pc : alu_out;  // ecall carries its own pc
    assign ex_out.store_data = rs2_val;

endmodule

// File: hdl/fetch_stage.sv
// Instruction fetch stage
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module fetch_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              move,
    input  logic              halt,
    output logic              imem_req,
    output logic [`XLEN-1:0]  imem_addr,
    input  logic              imem_resp,
    input  logic [`XLEN-1:0]  imem_rdata,
    output logic              if_valid,
    output logic [`XLEN-1:0]  if_pc,
    output logic [`XLEN-1:0]  if_instr,
    output logic              halted
);

    logic              rst_q;
    logic              start;
    logic [`XLEN-1:0]  pc_q;         // address of the word in flight
    logic [`XLEN-1:0]  instr_buf;
    logic              buf_valid;
    logic              halted_q;

    always_ff @(posedge clk) begin
        rst_q <= rst;
    end

    // one boot request in the first cycle out of reset
    assign start = rst_q && !rst;

    assign imem_req  = start || (move && !halt && !halted_q);
    assign imem_addr = start ? pc_q : pc_q + `XLEN'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= `RESET_PC;
            buf_valid <= 1'b0;
            halted_q  <= 1'b0;
        end else begin
            if (imem_req) pc_q <= imem_addr;
            if (move) buf_valid <= 1'b0;
            else if (imem_resp) buf_valid <= 1'b1;  // response came early, hold it
            if (move && halt) halted_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_resp) instr_buf <= imem_rdata;
    end

    // the word handed to execute comes straight from memory when it lands on the move cycle
    assign if_valid = imem_resp || buf_valid;
    assign if_instr = imem_resp ? imem_rdata : instr_buf;
    assign if_pc    = pc_q;
    assign halted   = halted_q;

endmodule

// File: hdl/ex_mem_if.sv
// Execute to memory link
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

interface ex_mem_if import rv_isa_pkg::*; ();

    localparam int RW = $clog2(`REG_COUNT);

    logic              valid;
    rv_opcode_e        op;
    logic [RW-1:0]     rd;
    logic [`XLEN-1:0]  result;      // alu result, or effective address for lw/sw
    logic [`XLEN-1:0]  store_data;

    modport execute (
        output valid, op, rd, result, store_data
    );

    modport memory (
        input valid, op, rd, result, store_data
    );

endinterface

// File: hdl/pipe_ctrl_pkg.sv
// Pipeline control types

package pipe_ctrl_pkg;

    // which responses the current beat is still waiting for
    typedef enum logic [2:0] {
        idle,       // after reset, only the boot fetch is in flight
        wait_imem,
        wait_dmem,
        imem_dmem,
        moving      // nothing in flight, advance every cycle
    } stall_state_e;

endpackage

// File: hdl/rv_isa_pkg.sv
// RV32I subset instruction types

package rv_isa_pkg;

    // decoded instruction kind, op_illegal covers anything outside the subset
    typedef enum logic [3:0] {
        op_addi,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_lw,
        op_sw,
        op_ecall,
        op_illegal
    } rv_opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

endpackage

// File: hdl/rv_pipe_params.svh
// Pipeline parameters

`ifndef RV_PIPE_PARAMS_SVH
`define RV_PIPE_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000

`endif
